/* logic/tiny_core_pkg.sv */
package tiny_core_pkg;

    // ******************************
    // Control encodings
    // ******************************

    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB
    } alu_op_t;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_t;

    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_t;

    typedef enum logic [2:0] {WB_ALU, WB_LOAD, WB_PC4, WB_LT, WB_LTU} wb_sel_t;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_t;

    typedef enum logic [1:0] {IDLE_WB, FETCH, EXECUTE, MEMORY} stage_t;

    // ******************************
    // Instruction formats
    // ******************************

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

/* logic/core_ctrl_if.sv */
interface core_ctrl_if import tiny_core_pkg::*; ();
    alu_op_t     alu_op;
    op1_sel_t    op1_sel;
    op2_sel_t    op2_sel;
    logic [31:0] imm;
    wb_sel_t     wb_sel;
    logic        reg_write;
    logic [4:0]  rd;
    logic        load;
    logic [3:0]  store_mask;    // Byte enables before alignment, zero when not a store
    logic [1:0]  lane;          // Access width, 0 byte, 1 half-word, 2 word
    logic        sign_ext;
    pc_sel_t     pc_sel;
    logic [2:0]  branch_cond;
    logic        halt_req;
    logic        illegal;

    modport decode (output alu_op, op1_sel, op2_sel, imm, wb_sel, reg_write, rd, load,
                    store_mask, lane, sign_ext, pc_sel, branch_cond, halt_req, illegal);
    modport execute (input alu_op, op1_sel, op2_sel, imm, branch_cond);
    modport result (input imm, wb_sel, reg_write, rd, load, store_mask, lane, sign_ext,
                    pc_sel, halt_req, illegal);
endinterface

/* logic/stage_sequencer.sv */
module stage_sequencer import tiny_core_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  logic       ready,
    core_ctrl_if.result ctrl,
    input  logic [1:0] pc_low,
    output stage_t     stage,
    output logic       advance,
    output logic       start,
    output logic       hlt,
    output logic       error
);
    logic stopped;
    logic access_stage;
    logic misaligned;
    logic trap;

    assign stopped = hlt || error;
    assign misaligned = pc_low != 2'b00;
    assign access_stage = stage == FETCH ||
                          (stage == MEMORY && (ctrl.load || ctrl.store_mask != 4'b0000));
    assign trap = stage == EXECUTE && (ctrl.halt_req || ctrl.illegal || misaligned);

    // Bus stages wait for ready, a trap ends stepping for good
    assign advance = !stopped && !trap && (!access_stage || ready);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            stage <= IDLE_WB;
            start <= 1'b0;
            hlt <= 1'b0;
            error <= 1'b0;
        end else begin
            if (advance) begin
                stage <= stage_t'(stage + 2'd1);    // MEMORY wraps to IDLE_WB
                if (stage == MEMORY) begin
                    start <= 1'b1;                  // First real write back follows
                end
            end
            if (trap && !stopped) begin
                hlt <= ctrl.halt_req;
                error <= ctrl.illegal || misaligned;
            end
        end
    end
endmodule

/* logic/instruction_decode.sv */
module instruction_decode import tiny_core_pkg::*; (
    input  logic        clk,
    input  logic        nreset,
    input  logic [31:0] data_in,
    input  stage_t      stage,
    input  logic        advance,
    core_ctrl_if.decode ctrl
);
    localparam logic [31:0] NOP = 32'h0000_0013;       // ADDI x0, x0, 0
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    instr_u     instr;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            instr <= NOP;
        end else if (stage == FETCH && advance) begin
            instr <= data_in;
        end
    end

    assign opcode = opcode_t'(instr.r.opcode[6:2]);
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    // SLT and SLTU use the flags, so their ALU code is a don't care
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SLL;
            3'd4: return ALU_XOR;
            3'd5: return alt ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            3'd7: return ALU_AND;
            default: return ALU_SUB;
        endcase
    endfunction

    always_comb begin
        ctrl.alu_op = ALU_ADD;
        ctrl.op1_sel = OP1_RS1;
        ctrl.op2_sel = OP2_IMM;
        ctrl.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        ctrl.wb_sel = WB_ALU;
        ctrl.reg_write = 1'b0;
        ctrl.rd = instr.r.rd;
        ctrl.load = 1'b0;
        ctrl.store_mask = 4'b0000;
        ctrl.lane = funct3[1:0];
        ctrl.sign_ext = !funct3[2];
        ctrl.pc_sel = PC_SEQ;
        ctrl.branch_cond = funct3;
        ctrl.halt_req = 1'b0;
        ctrl.illegal = 1'b0;

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                if (opcode == OPC_OP) begin
                    ctrl.op2_sel = OP2_RS2;
                    ctrl.alu_op = alu_from_funct3(funct3, funct7[5]);
                    ctrl.illegal = funct7 != 7'h00 &&
                                   !(funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
                end else begin
                    ctrl.alu_op = alu_from_funct3(funct3, funct3 == 3'd5 && funct7[5]);
                    ctrl.illegal = (funct3 == 3'd1 && funct7 != 7'h00) ||
                                   (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
                end
                if (funct3 == 3'd2) begin
                    ctrl.wb_sel = WB_LT;
                end else if (funct3 == 3'd3) begin
                    ctrl.wb_sel = WB_LTU;
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.op1_sel = opcode == OPC_LUI ? OP1_ZERO : OP1_PC;
                ctrl.imm = {instr.u.imm, 12'h000};
                ctrl.reg_write = 1'b1;
            end
            OPC_JAL: begin
                ctrl.imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                            instr.j.imm11, instr.j.imm10_1, 1'b0};
                ctrl.wb_sel = WB_PC4;
                ctrl.reg_write = 1'b1;
                ctrl.pc_sel = PC_JAL;
            end
            OPC_JALR: begin
                ctrl.wb_sel = WB_PC4;
                ctrl.reg_write = 1'b1;
                ctrl.pc_sel = PC_JALR;
                ctrl.illegal = funct3 != 3'd0;
            end
            OPC_BRANCH: begin
                ctrl.op2_sel = OP2_RS2;
                ctrl.imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                            instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                ctrl.pc_sel = PC_BRANCH;
                ctrl.illegal = funct3[2:1] == 2'b01;
            end
            OPC_LOAD: begin
                ctrl.load = 1'b1;
                ctrl.wb_sel = WB_LOAD;
                ctrl.reg_write = 1'b1;
                ctrl.illegal = funct3[1:0] == 2'b11 || funct3 == 3'd6;
            end
            OPC_STORE: begin
                ctrl.imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                case (funct3)
                    3'd0: ctrl.store_mask = 4'b0001;
                    3'd1: ctrl.store_mask = 4'b0011;
                    3'd2: ctrl.store_mask = 4'b1111;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                ctrl.halt_req = instr == EBREAK;
                ctrl.illegal = instr != EBREAK;     // ECALL and CSR access are not supported
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (instr.r.opcode[1:0] != 2'b11) begin
            ctrl.illegal = 1'b1;
        end
    end
endmodule

/* logic/alu_execute.sv */
module alu_execute import tiny_core_pkg::*; (
    input  logic        clk,
    input  logic        nreset,
    input  stage_t      stage,
    input  logic        advance,
    core_ctrl_if.execute ctrl,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] pc,
    output logic [31:0] alu_result,
    output logic        lt,
    output logic        ltu,
    output logic        branch_taken
);
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1 = rs1_data;
            OP1_PC:  op1 = pc;
            default: op1 = 32'h0;
        endcase
    end

    assign op2 = ctrl.op2_sel == OP2_IMM ? ctrl.imm : rs2_data;
    assign shamt = op2[4:0];

    // Operands stay put until the next fetch, so the flags serve SLT and branches alike
    assign lt = $signed(op1) < $signed(op2);
    assign ltu = op1 < op2;

    always_comb begin
        case (ctrl.branch_cond)
            3'd0: branch_taken = op1 == op2;
            3'd1: branch_taken = op1 != op2;
            3'd4: branch_taken = lt;
            3'd5: branch_taken = !lt;
            3'd6: branch_taken = ltu;
            3'd7: branch_taken = !ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            alu_result <= 32'h0;
        end else if (stage == EXECUTE && advance) begin
            case (ctrl.alu_op)
                ALU_SLL: alu_result <= op1 << shamt;
                ALU_SRL: alu_result <= op1 >> shamt;
                ALU_SRA: alu_result <= $signed(op1) >>> shamt;
                ALU_AND: alu_result <= op1 & op2;
                ALU_OR:  alu_result <= op1 | op2;
                ALU_XOR: alu_result <= op1 ^ op2;
                ALU_SUB: alu_result <= op1 - op2;
                default: alu_result <= op1 + op2;   // Also the load and store address
            endcase
        end
    end
endmodule

/* logic/register_file.sv */
module register_file import tiny_core_pkg::*; (
    input  logic        clk,
    input  stage_t      stage,
    input  logic        advance,
    input  logic [31:0] data_in,
    input  logic [4:0]  rd,
    input  logic        reg_write,
    input  logic        start,
    input  logic [31:0] write_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);
    logic [31:0] regs [32];
    logic [4:0]  rs1;
    logic [4:0]  rs2;

    assign rs1 = data_in[19:15];        // Source fields straight off the bus
    assign rs2 = data_in[24:20];

    always_ff @(posedge clk) begin
        if (stage == IDLE_WB && advance && reg_write && start && rd != 5'd0) begin
            regs[rd] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == FETCH && advance) begin
            rs1_data <= rs1 == 5'd0 ? 32'h0 : regs[rs1];
            rs2_data <= rs2 == 5'd0 ? 32'h0 : regs[rs2];
        end
    end
endmodule

/* logic/result_writeback.sv */
module result_writeback import tiny_core_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        nreset,
    input  stage_t      stage,
    input  logic        advance,
    core_ctrl_if.result ctrl,
    input  logic [31:0] alu_result,
    input  logic        lt,
    input  logic        ltu,
    input  logic        branch_taken,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] data_in,
    output logic [31:0] pc,
    output logic [31:0] address,
    output logic [31:0] data_out,
    output logic [31:0] write_data,
    output logic        nrd,
    output logic [3:0]  nwr
);
    logic [31:0] next_pc;
    logic [31:0] link;
    logic [31:0] load_word;
    logic [31:0] load_shifted;
    logic [31:0] load_value;
    logic [1:0]  offset;
    logic        store;
    logic        mem_access;

    assign offset = alu_result[1:0];
    assign store = ctrl.store_mask != 4'b0000;
    assign mem_access = stage == MEMORY && (ctrl.load || store);

    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: next_pc = branch_taken ? pc + ctrl.imm : pc + 32'd4;
            PC_JAL:    next_pc = pc + ctrl.imm;
            PC_JALR:   next_pc = (rs1_data + ctrl.imm) & 32'hffff_fffe;
            default:   next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            pc <= RESET_PC;
        end else if (stage == MEMORY && advance) begin
            pc <= next_pc;
        end
    end

    // The pc has moved on by write back, so the link value is kept here
    always_ff @(posedge clk) begin
        if (stage == MEMORY && advance) begin
            link <= pc + 32'd4;
            load_word <= data_in;
        end
    end

    // ******************************
    // Bus side
    // ******************************

    assign address = mem_access ? alu_result : pc;
    assign data_out = rs2_data << {offset, 3'b000};
    assign nrd = !(stage == FETCH || (stage == MEMORY && ctrl.load));
    assign nwr = stage == MEMORY && store ? ~(ctrl.store_mask << offset) : 4'b1111;

    assign load_shifted = load_word >> {offset, 3'b000};

    always_comb begin
        case (ctrl.lane)
            2'd0: load_value = {{24{ctrl.sign_ext & load_shifted[7]}}, load_shifted[7:0]};
            2'd1: load_value = {{16{ctrl.sign_ext & load_shifted[15]}}, load_shifted[15:0]};
            default: load_value = load_word;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_LOAD: write_data = load_value;
            WB_PC4:  write_data = link;
            WB_LT:   write_data = {31'h0, lt};
            WB_LTU:  write_data = {31'h0, ltu};
            default: write_data = alu_result;
        endcase
    end
endmodule

/* logic/tiny_core.sv */
module tiny_core import tiny_core_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        nreset,
    output logic [31:0] address,
    input  logic [31:0] data_in,
    output logic [31:0] data_out,
    output logic        nrd,
    output logic [3:0]  nwr,
    input  logic        ready,
    output logic        hlt,
    output logic        error,
    output stage_t      stage
);
    logic        advance;
    logic        start;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_result;
    logic        lt;
    logic        ltu;
    logic        branch_taken;
    logic [31:0] pc;
    logic [31:0] write_data;

    core_ctrl_if ctrl ();

    stage_sequencer u_sequencer (
        .clk(clk),
        .nreset(nreset),
        .ready(ready),
        .ctrl(ctrl.result),
        .pc_low(pc[1:0]),
        .stage(stage),
        .advance(advance),
        .start(start),
        .hlt(hlt),
        .error(error)
    );

    instruction_decode u_decode (
        .clk(clk),
        .nreset(nreset),
        .data_in(data_in),
        .stage(stage),
        .advance(advance),
        .ctrl(ctrl.decode)
    );

    alu_execute u_execute (
        .clk(clk),
        .nreset(nreset),
        .stage(stage),
        .advance(advance),
        .ctrl(ctrl.execute),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .pc(pc),
        .alu_result(alu_result),
        .lt(lt),
        .ltu(ltu),
        .branch_taken(branch_taken)
    );

    register_file u_regs (
        .clk(clk),
        .stage(stage),
        .advance(advance),
        .data_in(data_in),
        .rd(ctrl.rd),
        .reg_write(ctrl.reg_write),
        .start(start),
        .write_data(write_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    result_writeback #(.RESET_PC(RESET_PC)) u_result (
        .clk(clk),
        .nreset(nreset),
        .stage(stage),
        .advance(advance),
        .ctrl(ctrl.result),
        .alu_result(alu_result),
        .lt(lt),
        .ltu(ltu),
        .branch_taken(branch_taken),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .data_in(data_in),
        .pc(pc),
        .address(address),
        .data_out(data_out),
        .write_data(write_data),
        .nrd(nrd),
        .nwr(nwr)
    );
endmodule

/* verification/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic nreset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        nreset = 1'b0;
        repeat (5) @(posedge clk);
        #1 nreset = 1'b1;
    end
endmodule

/* verification/program_memory.sv */
module program_memory (
    input  logic        clk,
    input  logic        nreset,
    input  logic        prog_sel,       // 0 selects program A, 1 program B
    input  logic [31:0] address,
    input  logic [31:0] wdata,
    input  logic        nrd,
    input  logic [3:0]  nwr,
    output logic [31:0] rdata,
    output logic        ready
);
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG = 7'b0110011;

    logic [31:0] mem [256];
    logic [31:0] image_a [256];
    logic [31:0] image_b [256];
    logic [1:0]  delay;
    logic        access;

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] itype(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jtype(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // ******************************
    // Program images
    // ******************************

    initial begin
        for (int i = 0; i < 256; i++) begin
            image_a[i] = 32'hc0de_0000 ^ (i * 32'h0001_0004);
            image_b[i] = 32'hb0b0_0000 ^ (i * 32'h0001_0004);
        end
        image_a[0] = utype(20'h12345, 1, OP_LUI);
        image_a[1] = itype(32'h678, 1, 0, 1, OP_IMM);
        image_a[2] = itype(-5, 0, 0, 2, OP_IMM);
        image_a[3] = itype(32'h200, 0, 0, 12, OP_IMM);     // Store base
        image_a[4] = rtype(7'h20, 2, 1, 0, 3);               // SUB
        image_a[5] = itype(4, 1, 1, 4, OP_IMM);              // SLLI
        image_a[6] = itype(32'h401, 2, 5, 5, OP_IMM);        // SRAI
        image_a[7] = itype(28, 2, 5, 6, OP_IMM);             // SRLI
        image_a[8] = rtype(7'h00, 4, 3, 4, 7);               // XOR
        image_a[9] = rtype(7'h00, 6, 5, 6, 8);               // OR
        image_a[10] = rtype(7'h00, 6, 1, 7, 9);              // AND
        image_a[11] = rtype(7'h00, 0, 2, 2, 10);             // SLT
        image_a[12] = rtype(7'h00, 1, 2, 3, 11);             // SLTU
        image_a[13] = rtype(7'h00, 10, 9, 0, 13);
        image_a[14] = rtype(7'h00, 11, 13, 0, 13);
        image_a[15] = utype(20'h00001, 14, OP_AUIPC);
        image_a[16] = stype(0, 3, 12, 2);
        image_a[17] = stype(4, 7, 12, 2);
        image_a[18] = stype(8, 8, 12, 2);
        image_a[19] = stype(12, 13, 12, 2);
        image_a[20] = stype(16, 14, 12, 2);
        image_a[21] = itype(32'h300, 0, 0, 15, OP_IMM);    // Load base
        image_a[22] = itype(0, 15, 0, 16, OP_LOAD);          // LB
        image_a[23] = itype(3, 15, 4, 17, OP_LOAD);          // LBU
        image_a[24] = itype(2, 15, 1, 18, OP_LOAD);          // LH
        image_a[25] = itype(0, 15, 5, 19, OP_LOAD);          // LHU
        for (int i = 0; i < 4; i++) begin
            image_a[26 + i] = stype(20 + 4 * i, 16 + i, 12, 2);
            image_a[30 + i] = stype(36 + i, 1, 12, 0);       // SB at every lane
        end
        image_a[34] = stype(40, 1, 12, 1);
        image_a[35] = stype(42, 1, 12, 1);
        image_a[36] = btype(8, 11, 10, 0);                   // BEQ not taken
        image_a[37] = btype(8, 11, 10, 1);                   // BNE taken
        image_a[38] = 32'h0;
        image_a[39] = btype(8, 0, 2, 4);                     // BLT taken
        image_a[40] = 32'h0;
        image_a[41] = btype(8, 0, 2, 5);                     // BGE not taken
        image_a[42] = btype(8, 1, 2, 6);                     // BLTU not taken
        image_a[43] = btype(8, 1, 2, 7);                     // BGEU taken
        image_a[44] = 32'h0;
        image_a[45] = jtype(8, 21);
        image_a[46] = 32'h0;
        image_a[47] = itype(32'hcd, 0, 0, 23, OP_IMM);      // Odd target, JALR clears bit 0
        image_a[48] = itype(0, 23, 0, 22, OP_JALR);
        image_a[49] = 32'h0;
        image_a[50] = 32'h0;
        image_a[51] = stype(44, 21, 12, 2);
        image_a[52] = stype(48, 22, 12, 2);
        image_a[53] = 32'h0010_0073;                        // EBREAK
        image_a[192] = 32'h80f1_7f82;                       // Load source at 0x300

        image_b[0] = itype(5, 0, 0, 1, OP_IMM);
        image_b[1] = itype(3, 1, 0, 2, OP_IMM);
        image_b[2] = stype(32'h100, 2, 0, 2);
        image_b[3] = 32'hffff_ffff;
    end

    assign access = !nrd || nwr != 4'b1111;
    assign rdata = mem[address[9:2]];

    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= prog_sel ? image_b[i] : image_a[i];
            end
        end else if (ready && nwr != 4'b1111) begin
            for (int b = 0; b < 4; b++) begin
                if (!nwr[b]) begin
                    mem[address[9:2]][8 * b +: 8] <= wdata[8 * b +: 8];
                end
            end
        end
    end

    // Ready comes 1 to 4 cycles into an access and lasts one cycle
    always_ff @(posedge clk) begin
        if (!nreset) begin
            ready <= 1'b0;
            delay <= 2'd0;
        end else if (ready) begin
            ready <= 1'b0;
            delay <= 2'($urandom % 4);
        end else if (access) begin
            if (delay == 2'd0) begin
                ready <= 1'b1;
            end else begin
                delay <= delay - 2'd1;
            end
        end
    end
endmodule

/* verification/tb_tiny_core.sv */
module tb_tiny_core import tiny_core_pkg::*; ();
    localparam int INSTR_COUNT = 52;                // 48 in program A, 4 in program B
    localparam int WATCHDOG = INSTR_COUNT * 4 * 4 * 10 + 200;

    logic        clk;
    logic        power_on_nreset;
    logic        restart_n;
    logic        nreset;
    logic        prog_sel;
    logic [31:0] address;
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic        nrd;
    logic [3:0]  nwr;
    logic        ready;
    logic        hlt;
    logic        error;
    stage_t      stage;

    logic [31:0] fetch_exp [64];
    logic [31:0] store_addr [32];
    logic [3:0]  store_nwr [32];
    logic [31:0] store_data [32];
    int          fetch_total = 0;
    int          store_total = 0;
    int          fetch_idx = 0;
    int          store_idx = 0;
    int          mismatch_count = 0;
    int          protocol_count = 0;

    assign nreset = power_on_nreset && restart_n;

    tb_clock u_clock (.clk(clk), .nreset(power_on_nreset));

    program_memory u_memory (
        .clk(clk), .nreset(nreset), .prog_sel(prog_sel), .address(address),
        .wdata(wdata), .nrd(nrd), .nwr(nwr), .rdata(rdata), .ready(ready)
    );

    tiny_core #(.RESET_PC(32'h0)) DUT (
        .clk(clk), .nreset(nreset), .address(address), .data_in(rdata),
        .data_out(wdata), .nrd(nrd), .nwr(nwr), .ready(ready), .hlt(hlt),
        .error(error), .stage(stage)
    );

    task automatic expect_fetches(input logic [31:0] first, input int count);
        for (int i = 0; i < count; i++) begin
            fetch_exp[fetch_total] = first + 4 * i;
            fetch_total++;
        end
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [3:0] m, input logic [31:0] d);
        store_addr[store_total] = a;
        store_nwr[store_total] = m;
        store_data[store_total] = d;
        store_total++;
    endtask

    function automatic bit fetch_ok(input int idx, input logic [31:0] a);
        return idx < fetch_total && fetch_exp[idx] == a;
    endfunction

    function automatic bit store_ok(input int idx, input logic [31:0] a, input logic [31:0] d,
                                    input logic [3:0] m);
        logic [31:0] lanes;
        lanes = {{8{!m[3]}}, {8{!m[2]}}, {8{!m[1]}}, {8{!m[0]}}};
        return idx < store_total && a == store_addr[idx] && m == store_nwr[idx] &&
               ((d ^ store_data[idx]) & lanes) == 32'h0;
    endfunction

    always @(posedge clk) begin
        if (nreset && ready && stage == FETCH && !nrd) begin
            fetch_idx <= fetch_idx + 1;
        end
        if (nreset && ready && nwr != 4'b1111) begin
            store_idx <= store_idx + 1;
        end
    end

    // ******************************
    // Checks
    // ******************************

    reset_state: assert property (@(posedge clk) !nreset |=>
            nrd && nwr == 4'b1111 && !hlt && !error && stage == IDLE_WB)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: outputs not in their reset state", $time);
        end

    fetch_order: assert property (@(posedge clk) disable iff (!nreset)
            (ready && stage == FETCH && !nrd) |-> fetch_ok(fetch_idx, address))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: fetch %0d from %h", $time, $sampled(fetch_idx),
                     $sampled(address));
        end

    store_value: assert property (@(posedge clk) disable iff (!nreset)
            (ready && nwr != 4'b1111) |-> store_ok(store_idx, address, wdata, nwr))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: store %0d to %h data %h nwr %b", $time,
                     $sampled(store_idx), $sampled(address), $sampled(wdata), $sampled(nwr));
        end

    stall_hold: assert property (@(posedge clk) disable iff (!nreset)
            (!ready && (!nrd || nwr != 4'b1111)) |=>
            $stable(stage) && $stable(address) && $stable(nrd) && $stable(nwr))
        else begin
            protocol_count++;
            $display("The bus outputs changed during a stall at %0t", $time);
        end

    frozen: assert property (@(posedge clk) disable iff (!nreset)
            (hlt || error) |=> $stable(stage) && nrd && nwr == 4'b1111)
        else begin
            protocol_count++;
            $display("The core kept running after halt or error at %0t", $time);
        end

    one_trap: assert property (@(posedge clk) disable iff (!nreset) !(hlt && error))
        else begin
            protocol_count++;
            $display("Halt and error were raised together at %0t", $time);
        end

    initial begin
        #WATCHDOG;
        $display("Timeout, the programs did not finish in time");
        $display("Errors: %0d mismatches, %0d protocol", mismatch_count, protocol_count);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h80cc_5aad));
        restart_n = 1'b1;
        prog_sel = 1'b0;

        expect_fetches(32'h00, 38);
        expect_fetches(32'h9c, 1);
        expect_fetches(32'ha4, 3);
        expect_fetches(32'hb4, 1);
        expect_fetches(32'hbc, 2);
        expect_fetches(32'hcc, 3);
        expect_fetches(32'h00, 4);                  // Program B

        expect_store(32'h200, 4'b0000, 32'h1234_567d);
        expect_store(32'h204, 4'b0000, 32'h3171_31fd);
        expect_store(32'h208, 4'b0000, 32'hffff_ffff);
        expect_store(32'h20c, 4'b0000, 32'h0000_0009);
        expect_store(32'h210, 4'b0000, 32'h0000_103c);
        expect_store(32'h214, 4'b0000, 32'hffff_ff82);
        expect_store(32'h218, 4'b0000, 32'h0000_0080);
        expect_store(32'h21c, 4'b0000, 32'hffff_80f1);
        expect_store(32'h220, 4'b0000, 32'h0000_7f82);
        expect_store(32'h224, 4'b1110, 32'h0000_0078);
        expect_store(32'h225, 4'b1101, 32'h0000_7800);
        expect_store(32'h226, 4'b1011, 32'h0078_0000);
        expect_store(32'h227, 4'b0111, 32'h7800_0000);
        expect_store(32'h228, 4'b1100, 32'h0000_5678);
        expect_store(32'h22a, 4'b0011, 32'h5678_0000);
        expect_store(32'h22c, 4'b0000, 32'h0000_00b8);
        expect_store(32'h230, 4'b0000, 32'h0000_00c4);
        expect_store(32'h100, 4'b0000, 32'h0000_0008);

        wait (hlt || error);
        repeat (4) @(posedge clk);
        assert (hlt && !error && store_idx == 17) else begin
            protocol_count++;
            $display("Program A did not halt cleanly after all of its stores");
        end
        #1 restart_n = 1'b0;
        prog_sel = 1'b1;
        repeat (5) @(posedge clk);
        #1 restart_n = 1'b1;

        wait (hlt || error);
        repeat (4) @(posedge clk);
        assert (error && !hlt) else begin
            protocol_count++;
            $display("Program B did not stop with an error");
        end
        assert (fetch_idx == fetch_total && store_idx == store_total) else begin
            protocol_count++;
            $display("Only %0d fetches and %0d stores were seen", fetch_idx, store_idx);
        end

        $display("Errors: %0d mismatches, %0d protocol", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

/* sources.f */
logic/tiny_core_pkg.sv
logic/core_ctrl_if.sv
logic/stage_sequencer.sv
logic/instruction_decode.sv
logic/alu_execute.sv
logic/register_file.sv
logic/result_writeback.sv
logic/tiny_core.sv
verification/tb_clock.sv
verification/program_memory.sv
verification/tb_tiny_core.sv
